/* build.f */
verilog/atom_pkg.sv
verilog/atom_timing.sv
verilog/atom_decode.sv
verilog/atom_pia.sv
verilog/atom_latches.sv
verilog/atom_read_mux.sv
verilog/atom_io.sv
dv/atom_io_tb.sv

/* Bender.yml */
package:
  name: atom_io

sources:
  - verilog/atom_pkg.sv
  - verilog/atom_timing.sv
  - verilog/atom_decode.sv
  - verilog/atom_pia.sv
  - verilog/atom_latches.sv
  - verilog/atom_read_mux.sv
  - verilog/atom_io.sv
  - target: test
    files:
      - dv/atom_io_tb.sv

/* dv/atom_io_tb.sv */
// ====================
// Atom I/O testbench
// Clock enable rates, cassette tone, PIA, ROM latch, decode, read mux
// and lock snoop checked from a stimulus table and directed steps
// ====================

`timescale 1ns/1ps
`default_nettype none

module atom_io_tb;
   import atom_pkg::*;

   localparam int TABLE_LEN   = 32;
   localparam int CYCLE_LIMIT = TABLE_LEN * 30 + 3000;

   // DUT inputs
   logic         clk25;
   logic         reset;
   turbo_e       turbo;
   addr_t        address;
   byte_t        wdata;
   logic         rnw;
   byte_t        ram_dout;
   logic [5:0]   keyout;
   logic         shift_n;
   logic         ctrl_n;
   logic         rept_n;
   logic         cas_in;
   logic         fs_n;

   // DUT outputs
   byte_t        cpu_din;
   logic         cpu_clken;
   byte_t        pia_pa;
   nibble_t      pia_pc;
   logic         cas_out;
   logic         lock;
   logic         rom_sel;

   // ====================
   // Stimulus table
   // ====================
   turbo_e       t_turbo [TABLE_LEN];
   addr_t        t_addr [TABLE_LEN];
   byte_t        t_wdata [TABLE_LEN];
   logic         t_rnw [TABLE_LEN];
   byte_t        t_ram [TABLE_LEN];
   logic [5:0]   t_key [TABLE_LEN];
   logic         t_shift [TABLE_LEN];
   logic         t_ctrl [TABLE_LEN];
   byte_t        e_din [TABLE_LEN];
   logic         e_din_chk [TABLE_LEN];
   byte_t        e_pa [TABLE_LEN];
   nibble_t      e_pc [TABLE_LEN];
   logic         e_lock [TABLE_LEN];
   logic         e_rom_sel [TABLE_LEN];

   int           n_entries = 0;
   int           cycles = 0;
   int           rel_cycle;
   int           seed;
   // Random RAM byte and key columns for the next entry
   byte_t        nr;
   logic [5:0]   nk;

   atom_io dut_i (.clk25, .reset, .turbo, .address, .wdata, .rnw, .ram_dout,
      .keyout, .shift_n, .ctrl_n, .rept_n, .cas_in, .fs_n, .cpu_din, .cpu_clken,
      .pia_pa, .pia_pc, .cas_out, .lock, .rom_sel);

   // 10 MHz bench clock
   initial
   begin
      clk25 = 1'b0;
      forever #50 clk25 = ~clk25;
   end

   // Run length guard
   always @(posedge clk25)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   // ====================
   // Helpers
   // ====================

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      if (act !== exp)
      begin
         $display("FAILED time=%0t %s expected=%02h actual=%02h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
      if (act !== exp)
      begin
         $display("FAILED time=%0t %s expected=%01h actual=%01h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
         abort_run();
      end
   endtask

   // New random column values
   task automatic roll();
      int rnd;
      rnd = $urandom;
      nr = rnd[7:0];
      nk = rnd[13:8];
   endtask

   task automatic add_entry(input turbo_e t, input addr_t a, input byte_t d, input logic r,
      input logic sh, input logic ct, input byte_t din, input logic chk,
      input byte_t pa, input nibble_t pc, input logic lk, input logic rs);
      if (n_entries >= TABLE_LEN)
      begin
         $display("Stimulus table is larger than its %0d slots", TABLE_LEN);
         abort_run();
      end
      t_turbo[n_entries]   = t;
      t_addr[n_entries]    = a;
      t_wdata[n_entries]   = d;
      t_rnw[n_entries]     = r;
      t_ram[n_entries]     = nr;
      t_key[n_entries]     = nk;
      t_shift[n_entries]   = sh;
      t_ctrl[n_entries]    = ct;
      e_din[n_entries]     = din;
      e_din_chk[n_entries] = chk;
      e_pa[n_entries]      = pa;
      e_pc[n_entries]      = pc;
      e_lock[n_entries]    = lk;
      e_rom_sel[n_entries] = rs;
      n_entries = n_entries + 1;
   endtask

   // One strobe, the commit edge, then the sampling point
   task automatic wait_strobe();
      @(negedge clk25);
      while (!cpu_clken)
         @(negedge clk25);
      @(posedge clk25);
      @(negedge clk25);
   endtask

   task automatic bus_access(input turbo_e t, input addr_t a, input byte_t d, input logic r);
      @(posedge clk25);
      turbo   <= t;
      address <= a;
      wdata   <= d;
      rnw     <= r;
      wait_strobe();
   endtask

   // Gate rule on the port C value written, tone from register 2 bit 4
   task automatic check_cas_gate(input nibble_t pc);
      logic exp;
      exp = pc[0] && !(pc[1] && !cpu_din[4]);
      check_nibble("cpu_din[3:0]", pc, cpu_din[3:0]);
      check_bit("cas_out", exp, cas_out);
   endtask

   task automatic count_pulses(input turbo_e t, input int expected);
      int n;
      @(posedge clk25);
      turbo <= t;
      // Let the registered strobe settle on the new rate
      repeat (2) @(posedge clk25);
      n = 0;
      repeat (100)
      begin
         @(negedge clk25);
         if (cpu_clken)
            n = n + 1;
      end
      if (n != expected)
      begin
         $display("FAILED time=%0t cpu_clken pulses expected=%0d actual=%0d",
            $time, expected, n);
         abort_run();
      end
   endtask

   task automatic apply_entry(input int i);
      @(posedge clk25);
      turbo    <= t_turbo[i];
      address  <= t_addr[i];
      wdata    <= t_wdata[i];
      rnw      <= t_rnw[i];
      ram_dout <= t_ram[i];
      keyout   <= t_key[i];
      shift_n  <= t_shift[i];
      ctrl_n   <= t_ctrl[i];
      wait_strobe();
      if (e_din_chk[i])
         check_byte("cpu_din", e_din[i], cpu_din);
      check_byte("pia_pa", e_pa[i], pia_pa);
      check_nibble("pia_pc", e_pc[i], pia_pc);
      check_bit("lock", e_lock[i], lock);
      check_bit("rom_sel", e_rom_sel[i], rom_sel);
   endtask

   // Starts from port A 00, port C 3, latch 00 and lock 0
   task automatic build_table();
      roll();
      add_entry(TURBO_4MHZ, 16'hB000, 8'hA5, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h3, 0, 0);
      add_entry(TURBO_4MHZ, 16'hB000, 8'h00, 1'b1, 1'b1, 1'b1, 8'hA5, 1'b1, 8'hA5, 4'h3, 0, 0);
      // Port C keeps the low nibble only
      add_entry(TURBO_4MHZ, 16'hB002, 8'h0C, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'hC, 0, 0);
      add_entry(TURBO_4MHZ, 16'hB002, 8'hF9, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h9, 0, 0);
      // Bit set/reset on PC1, PC3, none, PC2 and PC0 in turn
      add_entry(TURBO_4MHZ, 16'hB003, 8'h03, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'hB, 0, 0);
      add_entry(TURBO_4MHZ, 16'hB003, 8'h06, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h3, 0, 0);
      add_entry(TURBO_4MHZ, 16'hB003, 8'h8F, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h3, 0, 0);
      add_entry(TURBO_4MHZ, 16'hB003, 8'h05, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h7, 0, 0);
      add_entry(TURBO_4MHZ, 16'hB003, 8'h00, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 0, 0);
      // Port B read back
      roll();
      add_entry(TURBO_4MHZ, 16'hB001, 8'h00, 1'b1, 1'b0, 1'b1, {1'b0, 1'b1, nk}, 1'b1,
         8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_1MHZ, 16'hB001, 8'h00, 1'b1, 1'b1, 1'b0, {1'b1, 1'b0, nk}, 1'b1,
         8'hA5, 4'h6, 0, 0);
      add_entry(TURBO_4MHZ, 16'hB003, 8'h00, 1'b1, 1'b1, 1'b1, 8'h00, 1'b1, 8'hA5, 4'h6, 0, 0);
      // ROM latch and banked ROM select
      add_entry(TURBO_4MHZ, 16'hBFFF, 8'h5A, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 0, 0);
      add_entry(TURBO_4MHZ, 16'hBFFF, 8'h00, 1'b1, 1'b1, 1'b1, 8'h5A, 1'b1, 8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'hA000, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 1);
      add_entry(TURBO_4MHZ, 16'hBFFF, 8'h07, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'hA000, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 0);
      add_entry(TURBO_4MHZ, 16'hBFFF, 8'h00, 1'b1, 1'b1, 1'b1, 8'h07, 1'b1, 8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'hC000, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 1);
      roll();
      add_entry(TURBO_4MHZ, 16'hFFFF, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 1);
      add_entry(TURBO_4MHZ, 16'hBFFF, 8'hF3, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'hAFFF, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 1);
      // Empty PL8 slot and then plain RAM
      roll();
      add_entry(TURBO_4MHZ, 16'hB400, 8'h00, 1'b1, 1'b1, 1'b1, 8'h00, 1'b1, 8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'hB40F, 8'h00, 1'b1, 1'b1, 1'b1, 8'h00, 1'b1, 8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'hB410, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'h1234, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 0);
      // Lock snoop ignores reads and neighbouring bytes
      roll();
      add_entry(TURBO_4MHZ, 16'h00E7, 8'h20, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 0, 0);
      add_entry(TURBO_4MHZ, 16'h00E7, 8'h20, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 1, 0);
      roll();
      add_entry(TURBO_4MHZ, 16'h00E7, 8'h00, 1'b1, 1'b1, 1'b1, nr, 1'b1, 8'hA5, 4'h6, 1, 0);
      add_entry(TURBO_4MHZ, 16'h00E7, 8'hDF, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 0, 0);
      add_entry(TURBO_2MHZ, 16'h00E7, 8'hFF, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 1, 0);
      add_entry(TURBO_4MHZ, 16'h00E6, 8'h00, 1'b0, 1'b1, 1'b1, 8'h00, 1'b0, 8'hA5, 4'h6, 1, 0);
   endtask

   // ====================
   // Main sequence
   // ====================
   initial
   begin
      int tone_at;
      seed     = $urandom(34566);
      reset    = 1'b1;
      turbo    = TURBO_4MHZ;
      address  = 16'h0000;
      wdata    = 8'h00;
      rnw      = 1'b1;
      ram_dout = 8'h00;
      keyout   = 6'h3F;
      shift_n  = 1'b1;
      ctrl_n   = 1'b1;
      rept_n   = 1'b1;
      cas_in   = 1'b0;
      fs_n     = 1'b1;
      build_table();

      repeat (5) @(posedge clk25);
      reset <= 1'b0;
      @(negedge clk25);
      rel_cycle = cycles;
      check_byte("pia_pa", 8'h00, pia_pa);
      check_nibble("pia_pc", 4'h0, pia_pc);
      check_bit("lock", 1'b0, lock);
      check_bit("cas_out", 1'b0, cas_out);

      // Tone at 4 MHz with PC1 and PC0 set so cas_out follows it
      bus_access(TURBO_4MHZ, 16'hB002, 8'h03, 1'b0);
      bus_access(TURBO_4MHZ, 16'hB002, 8'h00, 1'b1);
      while (!cpu_din[4])
      begin
         check_cas_gate(4'h3);
         @(negedge clk25);
      end
      check_cas_gate(4'h3);
      tone_at = cycles - rel_cycle;
      if (tone_at < 1275 || tone_at > 1325)
      begin
         $display("FAILED time=%0t cas_tone toggle cycles expected=1275..1325 actual=%0d",
            $time, tone_at);
         abort_run();
      end

      // Strobe rates over 100 cycles
      count_pulses(TURBO_1MHZ, 4);
      count_pulses(TURBO_2MHZ, 8);
      count_pulses(TURBO_4MHZ, 16);

      for (int i = 0; i < n_entries; i++)
         apply_entry(i);

      // PC0 alone gives a steady high output
      bus_access(TURBO_4MHZ, 16'hB002, 8'h01, 1'b0);
      bus_access(TURBO_4MHZ, 16'hB002, 8'h00, 1'b1);
      check_nibble("pia_pc", 4'h1, pia_pc);
      repeat (30)
      begin
         check_cas_gate(4'h1);
         @(negedge clk25);
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/atom_io.sv */
// ====================
// Atom I/O top
// Timing, decode, PIA, latches and read mux on the CPU bus
// ====================

`timescale 1ns/1ps
`default_nettype none

module atom_io
(
   input  wire               clk25,
   input  wire               reset,
   input  atom_pkg::turbo_e  turbo,
   input  atom_pkg::addr_t   address,
   input  atom_pkg::byte_t   wdata,
   input  wire               rnw,
   input  atom_pkg::byte_t   ram_dout,
   input  wire  [5:0]        keyout,
   input  wire               shift_n,
   input  wire               ctrl_n,
   input  wire               rept_n,
   input  wire               cas_in,
   input  wire               fs_n,
   output atom_pkg::byte_t   cpu_din,
   output logic              cpu_clken,
   output atom_pkg::byte_t   pia_pa,
   output atom_pkg::nibble_t pia_pc,
   output logic              cas_out,
   output logic              lock,
   output logic              rom_sel
);
   import atom_pkg::*;

   logic      cas_tone;
   logic      pia_cs;
   logic      pl8_cs;
   logic      latch_cs;
   logic      lock_hit;
   byte_t     pia_dout;
   byte_t     rom_latch;
   rom_bank_t rom_bank;

   atom_timing timing_i (.clk25, .reset, .turbo, .cpu_clken, .cas_tone);

   atom_decode decode_i (.address, .rom_bank, .pia_cs, .pl8_cs, .latch_cs,
      .lock_hit, .rom_sel);

   // Execute stage, registers written on the strobe
   atom_pia pia_i (.clk25, .reset, .cpu_clken, .pia_cs, .rnw, .address, .wdata,
      .keyout, .shift_n, .ctrl_n, .rept_n, .cas_in, .fs_n, .cas_tone, .pia_pa,
      .pia_pc, .pia_dout);

   atom_latches latches_i (.clk25, .reset, .cpu_clken, .rnw, .latch_cs, .lock_hit,
      .wdata, .rom_latch, .rom_bank, .lock);

   atom_read_mux read_mux_i (.pia_cs, .pl8_cs, .latch_cs, .pia_dout, .rom_latch,
      .ram_dout, .cas_tone, .pia_pc, .cpu_din, .cas_out);

endmodule

`default_nettype wire

/* verilog/atom_read_mux.sv */
// ====================
// Atom read mux
// CPU read data select and cassette output gate
// ====================

`timescale 1ns/1ps
`default_nettype none

module atom_read_mux
(
   input  wire               pia_cs,
   input  wire               pl8_cs,
   input  wire               latch_cs,
   input  atom_pkg::byte_t   pia_dout,
   input  atom_pkg::byte_t   rom_latch,
   input  atom_pkg::byte_t   ram_dout,
   input  wire               cas_tone,
   input  atom_pkg::nibble_t pia_pc,
   output atom_pkg::byte_t   cpu_din,
   output logic              cas_out
);
   import atom_pkg::*;

   // Priority PIA, PL8, latch, then RAM
   // Nothing fitted in the PL8 slot so it reads zero
   assign cpu_din = pia_cs   ? pia_dout  :
                    pl8_cs   ? 8'h00     :
                    latch_cs ? rom_latch :
                               ram_dout;

   // PC0 enables the output and PC1 chops it with the tone
   // Same as the two NANDs and inverter on the board
   assign cas_out = pia_pc[0] && !(pia_pc[1] && !cas_tone);

endmodule

`default_nettype wire

/* verilog/atom_latches.sv */
// ====================
// Atom latches
// ROM bank latch at BFFF and snoop of the lock flag byte
// ====================

`timescale 1ns/1ps
`default_nettype none

module atom_latches
(
   input  wire                 clk25,
   input  wire                 reset,
   input  wire                 cpu_clken,
   input  wire                 rnw,
   input  wire                 latch_cs,
   input  wire                 lock_hit,
   input  atom_pkg::byte_t     wdata,
   output atom_pkg::byte_t     rom_latch,
   output atom_pkg::rom_bank_t rom_bank,
   output logic                lock
);
   import atom_pkg::*;

   logic wr_cycle;

   // CPU write, one strobe wide
   assign wr_cycle = cpu_clken && !rnw;

   // ROM latch, full byte kept for read back
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         rom_latch <= '0;
      else if (wr_cycle && latch_cs)
         rom_latch <= wdata;
   end

   // Bank select field
   assign rom_bank = rom_latch[2:0];

   // Lock flag copied from writes to the lock byte
   // The RAM write itself still happens in external memory
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (wr_cycle && lock_hit)
         lock <= wdata[LOCK_BIT];
   end

endmodule

`default_nettype wire

/* verilog/atom_pia.sv */
// ====================
// Atom 8255 PIA
// Fixed directions: port A out, port B in, port C low out and high in,
// with bit set/reset on the control register
// ====================

`timescale 1ns/1ps
`default_nettype none

module atom_pia
(
   input  wire                clk25,
   input  wire                reset,
   input  wire                cpu_clken,
   input  wire                pia_cs,
   input  wire                rnw,
   input  atom_pkg::addr_t    address,
   input  atom_pkg::byte_t    wdata,
   input  wire  [5:0]         keyout,
   input  wire                shift_n,
   input  wire                ctrl_n,
   input  wire                rept_n,
   input  wire                cas_in,
   input  wire                fs_n,
   input  wire                cas_tone,
   output atom_pkg::byte_t    pia_pa,
   output atom_pkg::nibble_t  pia_pc,
   output atom_pkg::byte_t    pia_dout
);
   import atom_pkg::*;

   logic  wr_en;
   byte_t pia_pb;
   byte_t pc_in;

   // Write qualified by the bus strobe
   assign wr_en = cpu_clken && pia_cs && !rnw;

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pia_pa <= '0;
         pia_pc <= '0;
      end
      else if (wr_en)
      begin
         case (address[1:0])
            2'b00: pia_pa <= wdata;
            2'b10: pia_pc <= wdata[3:0];
            // Control, bit set/reset only when bit 7 is clear
            2'b11:
            begin
               if (!wdata[7])
                  pia_pc[wdata[2:1]] <= wdata[0];
            end
            default: ;
         endcase
      end
   end

   // ====================
   // Read back
   // ====================

   // Keyboard columns plus modifier keys
   assign pia_pb = {shift_n, ctrl_n, keyout};
   // Upper port C is live inputs
   assign pc_in  = {fs_n, rept_n, cas_in, cas_tone, pia_pc};

   always_comb
   begin
      case (address[1:0])
         2'b00:   pia_dout = pia_pa;
         2'b01:   pia_dout = pia_pb;
         2'b10:   pia_dout = pc_in;
         // Control register not readable
         default: pia_dout = '0;
      endcase
   end

endmodule

`default_nettype wire

/* verilog/atom_decode.sv */
// ====================
// Atom address decoder
// Chip selects for the PIA, PL8 slot, ROM latch and lock byte,
// plus the ROM select for the upper memory map
// ====================

`timescale 1ns/1ps
`default_nettype none

module atom_decode
(
   input  atom_pkg::addr_t     address,
   input  atom_pkg::rom_bank_t rom_bank,
   output logic                pia_cs,
   output logic                pl8_cs,
   output logic                latch_cs,
   output logic                lock_hit,
   output logic                rom_sel
);
   import atom_pkg::*;

   logic upper_rom;
   logic a000_rom;

   // I/O pages, 16 bytes each
   assign pia_cs   = (address[15:4] == PIA_PAGE);
   // Empty slot, reads back zero
   assign pl8_cs   = (address[15:4] == PL8_PAGE);
   assign latch_cs = (address == ROM_LATCH_ADDR);
   // Lock flag snoop, a RAM byte
   assign lock_hit = (address == LOCK_ADDR);

   // ====================
   // ROM map
   // ====================

   // C000-FFFF always ROM
   assign upper_rom = (address[15:14] == 2'b11);
   // A000-AFFF is banked, bank 7 leaves RAM there
   assign a000_rom  = (address[15:12] == 4'hA) && (rom_bank != ROM_BANK_OFF);
   assign rom_sel   = upper_rom || a000_rom;

   // Selects feeding the read mux never overlap
   always_comb
   begin
      a_cs_onehot : assert #0 ($onehot0({pia_cs, pl8_cs, latch_cs}))
         else $error("overlapping I/O selects");
   end

endmodule

`default_nettype wire

/* verilog/atom_timing.sv */
// ====================
// Atom timing
// Modulo-25 divider giving the CPU clock enable at 1, 2 or 4 MHz
// and the cassette tone derived from it
// ====================

`timescale 1ns/1ps
`default_nettype none

module atom_timing
(
   input  wire              clk25,
   input  wire              reset,
   input  atom_pkg::turbo_e turbo,
   output logic             cpu_clken,
   output logic             cas_tone
);
   import atom_pkg::*;

   clkdiv_t clkdiv;
   casdiv_t cas_div;
   logic    clken_next;

   // Divider 0..24, wraps
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         clkdiv <= '0;
      else if (clkdiv == CLKDIV_LAST)
         clkdiv <= '0;
      else
         clkdiv <= clkdiv + 5'd1;
   end

   // Enable points, upper half of the count never fires
   always_comb
   begin
      case (turbo)
         TURBO_1MHZ: clken_next = (clkdiv[3:0] == 4'd0) && !clkdiv[4];
         TURBO_2MHZ: clken_next = (clkdiv[2:0] == 3'd0) && !clkdiv[4];
         // 4 MHz and the spare code
         default:    clken_next = (clkdiv[1:0] == 2'd0) && !clkdiv[4];
      endcase
   end

   // Registered strobe plus tone divider on the strobe
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cpu_clken <= 1'b0;
         cas_div   <= '0;
         cas_tone  <= 1'b0;
      end
      else
      begin
         cpu_clken <= clken_next;
         if (cpu_clken)
         begin
            if (cas_div == CAS_DIV_LAST)
            begin
               cas_div  <= '0;
               cas_tone <= !cas_tone;
            end
            else
               cas_div <= cas_div + 8'd1;
         end
      end
   end

   // Enable is always a single-cycle pulse
   a_clken_single : assert property (@(posedge clk25) disable iff (reset)
      cpu_clken |=> !cpu_clken);

endmodule

`default_nettype wire

/* verilog/atom_pkg.sv */
// ====================
// Atom I/O package
// Widths, fixed addresses, divider limits and the turbo speed type
// shared by the memory-mapped I/O blocks
// ====================

`default_nettype none

package atom_pkg;

   // ====================
   // Vector types
   // ====================

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;
   // Port C output latch of the PIA
   typedef logic [3:0]  nibble_t;
   typedef logic [4:0]  clkdiv_t;
   typedef logic [7:0]  casdiv_t;
   // ROM bank field, low bits of the BFFF latch
   typedef logic [2:0]  rom_bank_t;

   // CPU speed select, code 3 also runs at 4 MHz
   typedef enum logic [1:0]
   {
      TURBO_1MHZ = 2'd0,
      TURBO_2MHZ = 2'd1,
      TURBO_4MHZ = 2'd2
   } turbo_e;

   // ====================
   // Constants
   // ====================

   // 25 MHz divided by 25 gives the 1 MHz base rate
   localparam clkdiv_t   CLKDIV_LAST    = 5'd24;
   // 208 enable pulses per tone half period
   localparam casdiv_t   CAS_DIV_LAST   = 8'd207;
   // Address bits 15..4 of the I/O pages
   localparam logic [11:0] PIA_PAGE     = 12'hB00;
   localparam logic [11:0] PL8_PAGE     = 12'hB40;
   localparam addr_t     ROM_LATCH_ADDR = 16'hBFFF;
   // Zero page byte holding the lock flag
   localparam addr_t     LOCK_ADDR      = 16'h00E7;
   localparam int        LOCK_BIT       = 5;
   // Bank value that maps RAM into A000-AFFF
   localparam rom_bank_t ROM_BANK_OFF   = 3'd7;

endpackage

`default_nettype wire
